// File: include/axi_defines.svh
`ifndef AXI_DEFINES_SVH
`define AXI_DEFINES_SVH

// Bus field widths
`define AXI_ADDR_BITS 32
`define AXI_DATA_BITS 32
`define AXI_LEN_BITS 4
`define AXI_SIZE_BITS 3
`define AXI_BURST_BITS 2
`define AXI_RESP_BITS 2

// Master-side ID, and slave-side ID with the master tag bit on top
`define AXI_ID_BITS 4
`define AXI_IDS_BITS 5

`define AXI_NUM_SLAVES 2

// Upper address field used for region decode
`define AXI_REGION_HI 31
`define AXI_REGION_LO 16

// Boot ROM and instruction memory
`define AXI_REGION_BASE0 16'h0000
`define AXI_REGION_BASE1 16'h0001

`endif

// File: rtl/axi_pkg.sv
`default_nettype none

package axi_pkg;

	// Tag bit carried above the master ID on the slave side
	typedef enum logic {
		MASTER_0 = 1'b0,
		MASTER_1 = 1'b1
	} master_e;

	// Read window of the address arbiter
	typedef enum logic [1:0] {
		AR_OPEN    = 2'd0,
		AR_WAIT_M0 = 2'd1,
		AR_WAIT_M1 = 2'd2
	} ar_state_e;

	// Decode-error slave
	typedef enum logic [1:0] {
		DS_IDLE = 2'd0,
		DS_TURN = 2'd1,
		DS_DATA = 2'd2
	} ds_state_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_e;

endpackage

`default_nettype wire

// File: rtl/ar_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_defines.svh"

module ar_arbiter import axi_pkg::*; (
	input  wire                         ACLK,
	input  wire                         ARESETn,

	input  wire  [`AXI_ID_BITS-1:0]     m0_arid,
	input  wire  [`AXI_ADDR_BITS-1:0]   m0_araddr,
	input  wire  [`AXI_LEN_BITS-1:0]    m0_arlen,
	input  wire  [`AXI_SIZE_BITS-1:0]   m0_arsize,
	input  wire  [`AXI_BURST_BITS-1:0]  m0_arburst,
	input  wire                         m0_arvalid,
	output logic                        m0_arready,

	input  wire  [`AXI_ID_BITS-1:0]     m1_arid,
	input  wire  [`AXI_ADDR_BITS-1:0]   m1_araddr,
	input  wire  [`AXI_LEN_BITS-1:0]    m1_arlen,
	input  wire  [`AXI_SIZE_BITS-1:0]   m1_arsize,
	input  wire  [`AXI_BURST_BITS-1:0]  m1_arburst,
	input  wire                         m1_arvalid,
	output logic                        m1_arready,

	output logic [`AXI_IDS_BITS-1:0]    ar_id,
	output logic [`AXI_ADDR_BITS-1:0]   ar_addr,
	output logic [`AXI_LEN_BITS-1:0]    ar_len,
	output logic [`AXI_SIZE_BITS-1:0]   ar_size,
	output logic [`AXI_BURST_BITS-1:0]  ar_burst,
	output logic                        ar_valid,
	input  wire                         ar_ready,

	input  wire                         m0_rvalid,
	input  wire                         m0_rready,
	input  wire                         m0_rlast,
	input  wire                         m1_rvalid,
	input  wire                         m1_rready,
	input  wire                         m1_rlast
);

	master_e   prio;
	master_e   sel;
	ar_state_e state;
	ar_state_e state_nxt;
	logic      req_valid;
	logic      ar_fire;
	logic      last_m0;
	logic      last_m1;

	//////////////////////////////////////////////////////////////////////
	// Grant and request mux
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (m0_arvalid && m1_arvalid)
			sel = prio;
		else if (m1_arvalid)
			sel = MASTER_1;
		else
			sel = MASTER_0;
	end

	always_comb begin
		if (sel == MASTER_1) begin
			ar_id     = {sel, m1_arid};
			ar_addr   = m1_araddr;
			ar_len    = m1_arlen;
			ar_size   = m1_arsize;
			ar_burst  = m1_arburst;
			req_valid = m1_arvalid;
		end else begin
			ar_id     = {sel, m0_arid};
			ar_addr   = m0_araddr;
			ar_len    = m0_arlen;
			ar_size   = m0_arsize;
			ar_burst  = m0_arburst;
			req_valid = m0_arvalid;
		end
	end

	assign ar_valid   = req_valid && (state == AR_OPEN);
	assign ar_fire    = ar_valid && ar_ready;
	assign m0_arready = ar_fire && (sel == MASTER_0);
	assign m1_arready = ar_fire && (sel == MASTER_1);

	// Loser of a tie goes first next time
	always_ff @(posedge ACLK) begin
		if (!ARESETn)
			prio <= MASTER_0;
		else if (ar_fire)
			prio <= (sel == MASTER_0) ? MASTER_1 : MASTER_0;
	end

	//////////////////////////////////////////////////////////////////////
	// Read window, one burst in flight
	//////////////////////////////////////////////////////////////////////

	assign last_m0 = m0_rvalid && m0_rready && m0_rlast;
	assign last_m1 = m1_rvalid && m1_rready && m1_rlast;

	always_comb begin
		state_nxt = state;
		case (state)
			AR_OPEN: begin
				if (ar_fire)
					state_nxt = (sel == MASTER_0) ? AR_WAIT_M0 : AR_WAIT_M1;
			end
			AR_WAIT_M0: begin
				if (last_m0)
					state_nxt = AR_OPEN;
			end
			AR_WAIT_M1: begin
				if (last_m1)
					state_nxt = AR_OPEN;
			end
			default: state_nxt = AR_OPEN;
		endcase
	end

	always_ff @(posedge ACLK) begin
		if (!ARESETn)
			state <= AR_OPEN;
		else
			state <= state_nxt;
	end

endmodule

`default_nettype wire

// File: rtl/slave_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_defines.svh"

module slave_port #(
	parameter int SLAVE_INDEX = 0
) (
	input  wire                         ACLK,
	input  wire                         ARESETn,

	input  wire  [`AXI_IDS_BITS-1:0]    ar_id,
	input  wire  [`AXI_ADDR_BITS-1:0]   ar_addr,
	input  wire  [`AXI_LEN_BITS-1:0]    ar_len,
	input  wire  [`AXI_SIZE_BITS-1:0]   ar_size,
	input  wire  [`AXI_BURST_BITS-1:0]  ar_burst,
	input  wire                         ar_valid,
	output logic                        hit,
	output logic                        port_arready,

	output logic [`AXI_IDS_BITS-1:0]    s_arid,
	output logic [`AXI_ADDR_BITS-1:0]   s_araddr,
	output logic [`AXI_LEN_BITS-1:0]    s_arlen,
	output logic [`AXI_SIZE_BITS-1:0]   s_arsize,
	output logic [`AXI_BURST_BITS-1:0]  s_arburst,
	output logic                        s_arvalid,
	input  wire                         s_arready,

	input  wire                         s_rvalid,
	input  wire                         s_rlast,
	output logic                        own_rvalid,
	input  wire                         s_rready,
	output logic                        owns
);

	localparam logic [`AXI_REGION_HI-`AXI_REGION_LO:0] REGION_BASE =
		(SLAVE_INDEX == 0) ? `AXI_REGION_BASE0 : `AXI_REGION_BASE1;

	// Region decode
	assign hit = (ar_addr[`AXI_REGION_HI:`AXI_REGION_LO] == REGION_BASE);

	assign s_arid       = ar_id;
	assign s_araddr     = ar_addr;
	assign s_arlen      = ar_len;
	assign s_arsize     = ar_size;
	assign s_arburst    = ar_burst;
	assign s_arvalid    = ar_valid && hit;
	assign port_arready = s_arvalid && s_arready;

	// Burst ownership, address handshake to last beat
	always_ff @(posedge ACLK) begin
		if (!ARESETn)
			owns <= 1'b0;
		else if (port_arready)
			owns <= 1'b1;
		else if (own_rvalid && s_rready && s_rlast)
			owns <= 1'b0;
	end

	// Stray beats from a slave we do not own never reach the mux
	assign own_rvalid = owns && s_rvalid;

endmodule

`default_nettype wire

// File: rtl/decode_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_defines.svh"

module decode_slave import axi_pkg::*; (
	input  wire                        ACLK,
	input  wire                        ARESETn,

	input  wire  [`AXI_IDS_BITS-1:0]   ds_arid,
	input  wire  [`AXI_LEN_BITS-1:0]   ds_arlen,
	input  wire                        ds_arvalid,
	output logic                       ds_arready,

	output logic [`AXI_IDS_BITS-1:0]   ds_rid,
	output logic                       ds_rlast,
	output logic                       ds_rvalid,
	input  wire                        ds_rready
);

	ds_state_e                  state;
	logic [`AXI_IDS_BITS-1:0]   rid_q;
	logic [`AXI_LEN_BITS-1:0]   beats_left;

	assign ds_arready = (state == DS_IDLE) && ds_arvalid;
	assign ds_rvalid  = (state == DS_DATA);
	assign ds_rlast   = ds_rvalid && (beats_left == '0);
	assign ds_rid     = rid_q;

	//////////////////////////////////////////////////////////////////////
	// Accept, one turnaround cycle, then len+1 error beats
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			state <= DS_IDLE;
		end else begin
			case (state)
				DS_IDLE: begin
					if (ds_arvalid)
						state <= DS_TURN;
				end
				DS_TURN: state <= DS_DATA;
				DS_DATA: begin
					if (ds_rready && ds_rlast)
						state <= DS_IDLE;
				end
				default: state <= DS_IDLE;
			endcase
		end
	end

	// Beat counter counts down to zero, zero means last
	always_ff @(posedge ACLK) begin
		if (ds_arready) begin
			rid_q      <= ds_arid;
			beats_left <= ds_arlen;
		end else if (ds_rvalid && ds_rready && !ds_rlast) begin
			beats_left <= beats_left - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/r_return_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_defines.svh"

module r_return_mux import axi_pkg::*; (
	input  wire  [`AXI_NUM_SLAVES-1:0]  owns,
	input  wire  [`AXI_NUM_SLAVES-1:0]  own_rvalid,
	input  wire  [`AXI_IDS_BITS-1:0]    s_rid   [0:`AXI_NUM_SLAVES-1],
	input  wire  [`AXI_DATA_BITS-1:0]   s_rdata [0:`AXI_NUM_SLAVES-1],
	input  wire  [`AXI_RESP_BITS-1:0]   s_rresp [0:`AXI_NUM_SLAVES-1],
	input  wire  [`AXI_NUM_SLAVES-1:0]  s_rlast,

	input  wire  [`AXI_IDS_BITS-1:0]    ds_rid,
	input  wire                         ds_rlast,
	input  wire                         ds_rvalid,

	output logic [`AXI_NUM_SLAVES-1:0]  src_rready,
	output logic                        ds_rready,

	output logic [`AXI_ID_BITS-1:0]     m0_rid,
	output logic [`AXI_DATA_BITS-1:0]   m0_rdata,
	output logic [`AXI_RESP_BITS-1:0]   m0_rresp,
	output logic                        m0_rlast,
	output logic                        m0_rvalid,
	input  wire                         m0_rready,

	output logic [`AXI_ID_BITS-1:0]     m1_rid,
	output logic [`AXI_DATA_BITS-1:0]   m1_rdata,
	output logic [`AXI_RESP_BITS-1:0]   m1_rresp,
	output logic                        m1_rlast,
	output logic                        m1_rvalid,
	input  wire                         m1_rready
);

	logic [`AXI_IDS_BITS-1:0]   sel_id;
	logic [`AXI_DATA_BITS-1:0]  sel_data;
	resp_e                      sel_resp;
	logic                       sel_last;
	logic                       sel_valid;
	logic                       sel_ready;
	master_e                    tag;

	//////////////////////////////////////////////////////////////////////
	// Source select, decode slave when no port owns the burst
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		sel_id    = ds_rid;
		sel_data  = '0;
		sel_resp  = RESP_DECERR;
		sel_last  = ds_rlast;
		sel_valid = ds_rvalid;
		for (int i = 0; i < `AXI_NUM_SLAVES; i++) begin
			if (owns[i]) begin
				sel_id    = s_rid[i];
				sel_data  = s_rdata[i];
				sel_resp  = resp_e'(s_rresp[i]);
				sel_last  = s_rlast[i];
				sel_valid = own_rvalid[i];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Steer by tag bit
	//////////////////////////////////////////////////////////////////////

	assign tag = master_e'(sel_id[`AXI_IDS_BITS-1]);

	assign m0_rid    = sel_id[`AXI_ID_BITS-1:0];
	assign m0_rdata  = sel_data;
	assign m0_rresp  = sel_resp;
	assign m0_rlast  = sel_last;
	assign m0_rvalid = sel_valid && (tag == MASTER_0);

	assign m1_rid    = sel_id[`AXI_ID_BITS-1:0];
	assign m1_rdata  = sel_data;
	assign m1_rresp  = sel_resp;
	assign m1_rlast  = sel_last;
	assign m1_rvalid = sel_valid && (tag == MASTER_1);

	// Ready of the addressed master back to the selected source only
	assign sel_ready  = sel_valid && ((tag == MASTER_0) ? m0_rready : m1_rready);
	assign src_rready = owns & {`AXI_NUM_SLAVES{sel_ready}};
	assign ds_rready  = ~(|owns) && sel_ready;

endmodule

`default_nettype wire

// File: rtl/axi_read_xbar.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_defines.svh"

module axi_read_xbar (
	input  wire                         ACLK,
	input  wire                         ARESETn,

	input  wire  [`AXI_ID_BITS-1:0]     m0_arid,
	input  wire  [`AXI_ADDR_BITS-1:0]   m0_araddr,
	input  wire  [`AXI_LEN_BITS-1:0]    m0_arlen,
	input  wire  [`AXI_SIZE_BITS-1:0]   m0_arsize,
	input  wire  [`AXI_BURST_BITS-1:0]  m0_arburst,
	input  wire                         m0_arvalid,
	output logic                        m0_arready,
	output logic [`AXI_ID_BITS-1:0]     m0_rid,
	output logic [`AXI_DATA_BITS-1:0]   m0_rdata,
	output logic [`AXI_RESP_BITS-1:0]   m0_rresp,
	output logic                        m0_rlast,
	output logic                        m0_rvalid,
	input  wire                         m0_rready,

	input  wire  [`AXI_ID_BITS-1:0]     m1_arid,
	input  wire  [`AXI_ADDR_BITS-1:0]   m1_araddr,
	input  wire  [`AXI_LEN_BITS-1:0]    m1_arlen,
	input  wire  [`AXI_SIZE_BITS-1:0]   m1_arsize,
	input  wire  [`AXI_BURST_BITS-1:0]  m1_arburst,
	input  wire                         m1_arvalid,
	output logic                        m1_arready,
	output logic [`AXI_ID_BITS-1:0]     m1_rid,
	output logic [`AXI_DATA_BITS-1:0]   m1_rdata,
	output logic [`AXI_RESP_BITS-1:0]   m1_rresp,
	output logic                        m1_rlast,
	output logic                        m1_rvalid,
	input  wire                         m1_rready,

	output logic [`AXI_IDS_BITS-1:0]    s_arid    [0:`AXI_NUM_SLAVES-1],
	output logic [`AXI_ADDR_BITS-1:0]   s_araddr  [0:`AXI_NUM_SLAVES-1],
	output logic [`AXI_LEN_BITS-1:0]    s_arlen   [0:`AXI_NUM_SLAVES-1],
	output logic [`AXI_SIZE_BITS-1:0]   s_arsize  [0:`AXI_NUM_SLAVES-1],
	output logic [`AXI_BURST_BITS-1:0]  s_arburst [0:`AXI_NUM_SLAVES-1],
	output logic [`AXI_NUM_SLAVES-1:0]  s_arvalid,
	input  wire  [`AXI_NUM_SLAVES-1:0]  s_arready,
	input  wire  [`AXI_IDS_BITS-1:0]    s_rid     [0:`AXI_NUM_SLAVES-1],
	input  wire  [`AXI_DATA_BITS-1:0]   s_rdata   [0:`AXI_NUM_SLAVES-1],
	input  wire  [`AXI_RESP_BITS-1:0]   s_rresp   [0:`AXI_NUM_SLAVES-1],
	input  wire  [`AXI_NUM_SLAVES-1:0]  s_rlast,
	input  wire  [`AXI_NUM_SLAVES-1:0]  s_rvalid,
	output logic [`AXI_NUM_SLAVES-1:0]  s_rready
);

	wire [`AXI_IDS_BITS-1:0]    ar_id;
	wire [`AXI_ADDR_BITS-1:0]   ar_addr;
	wire [`AXI_LEN_BITS-1:0]    ar_len;
	wire [`AXI_SIZE_BITS-1:0]   ar_size;
	wire [`AXI_BURST_BITS-1:0]  ar_burst;
	wire                        ar_valid;
	wire                        ar_ready;
	wire [`AXI_NUM_SLAVES-1:0]  hit;
	wire [`AXI_NUM_SLAVES-1:0]  port_arready;
	wire [`AXI_NUM_SLAVES-1:0]  own_rvalid;
	wire [`AXI_NUM_SLAVES-1:0]  owns;
	wire                        ds_arvalid;
	wire                        ds_arready;
	wire [`AXI_IDS_BITS-1:0]    ds_rid;
	wire                        ds_rlast;
	wire                        ds_rvalid;
	wire                        ds_rready;

	ar_arbiter ar_arbiter_inst (
		.ACLK       (ACLK),
		.ARESETn    (ARESETn),
		.m0_arid    (m0_arid),
		.m0_araddr  (m0_araddr),
		.m0_arlen   (m0_arlen),
		.m0_arsize  (m0_arsize),
		.m0_arburst (m0_arburst),
		.m0_arvalid (m0_arvalid),
		.m0_arready (m0_arready),
		.m1_arid    (m1_arid),
		.m1_araddr  (m1_araddr),
		.m1_arlen   (m1_arlen),
		.m1_arsize  (m1_arsize),
		.m1_arburst (m1_arburst),
		.m1_arvalid (m1_arvalid),
		.m1_arready (m1_arready),
		.ar_id      (ar_id),
		.ar_addr    (ar_addr),
		.ar_len     (ar_len),
		.ar_size    (ar_size),
		.ar_burst   (ar_burst),
		.ar_valid   (ar_valid),
		.ar_ready   (ar_ready),
		.m0_rvalid  (m0_rvalid),
		.m0_rready  (m0_rready),
		.m0_rlast   (m0_rlast),
		.m1_rvalid  (m1_rvalid),
		.m1_rready  (m1_rready),
		.m1_rlast   (m1_rlast)
	);

	//////////////////////////////////////////////////////////////////////
	// One port per mapped region
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < `AXI_NUM_SLAVES; i++) begin : g_port
		slave_port #(
			.SLAVE_INDEX (i)
		) slave_port_inst (
			.ACLK         (ACLK),
			.ARESETn      (ARESETn),
			.ar_id        (ar_id),
			.ar_addr      (ar_addr),
			.ar_len       (ar_len),
			.ar_size      (ar_size),
			.ar_burst     (ar_burst),
			.ar_valid     (ar_valid),
			.hit          (hit[i]),
			.port_arready (port_arready[i]),
			.s_arid       (s_arid[i]),
			.s_araddr     (s_araddr[i]),
			.s_arlen      (s_arlen[i]),
			.s_arsize     (s_arsize[i]),
			.s_arburst    (s_arburst[i]),
			.s_arvalid    (s_arvalid[i]),
			.s_arready    (s_arready[i]),
			.s_rvalid     (s_rvalid[i]),
			.s_rlast      (s_rlast[i]),
			.own_rvalid   (own_rvalid[i]),
			.s_rready     (s_rready[i]),
			.owns         (owns[i])
		);
	end

	// Unmapped addresses fall through to the decode slave
	assign ds_arvalid = ar_valid && !(|hit);
	assign ar_ready   = (|port_arready) || ds_arready;

	decode_slave decode_slave_inst (
		.ACLK       (ACLK),
		.ARESETn    (ARESETn),
		.ds_arid    (ar_id),
		.ds_arlen   (ar_len),
		.ds_arvalid (ds_arvalid),
		.ds_arready (ds_arready),
		.ds_rid     (ds_rid),
		.ds_rlast   (ds_rlast),
		.ds_rvalid  (ds_rvalid),
		.ds_rready  (ds_rready)
	);

	r_return_mux r_return_mux_inst (
		.owns       (owns),
		.own_rvalid (own_rvalid),
		.s_rid      (s_rid),
		.s_rdata    (s_rdata),
		.s_rresp    (s_rresp),
		.s_rlast    (s_rlast),
		.ds_rid     (ds_rid),
		.ds_rlast   (ds_rlast),
		.ds_rvalid  (ds_rvalid),
		.src_rready (s_rready),
		.ds_rready  (ds_rready),
		.m0_rid     (m0_rid),
		.m0_rdata   (m0_rdata),
		.m0_rresp   (m0_rresp),
		.m0_rlast   (m0_rlast),
		.m0_rvalid  (m0_rvalid),
		.m0_rready  (m0_rready),
		.m1_rid     (m1_rid),
		.m1_rdata   (m1_rdata),
		.m1_rresp   (m1_rresp),
		.m1_rlast   (m1_rlast),
		.m1_rvalid  (m1_rvalid),
		.m1_rready  (m1_rready)
	);

endmodule

`default_nettype wire

// File: bench/axi_read_xbar_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_defines.svh"

module axi_read_xbar_checker import axi_pkg::*; (
	input  wire                         ACLK,
	input  wire                         ARESETn,
	input  wire  [`AXI_NUM_SLAVES-1:0]  s_arvalid,
	input  wire                         m0_arvalid,
	input  wire                         m0_arready,
	input  wire  [`AXI_ID_BITS-1:0]     m0_rid,
	input  wire  [`AXI_DATA_BITS-1:0]   m0_rdata,
	input  wire  [`AXI_RESP_BITS-1:0]   m0_rresp,
	input  wire                         m0_rlast,
	input  wire                         m0_rvalid,
	input  wire                         m0_rready,
	input  wire                         m1_arvalid,
	input  wire                         m1_arready,
	input  wire  [`AXI_ID_BITS-1:0]     m1_rid,
	input  wire  [`AXI_DATA_BITS-1:0]   m1_rdata,
	input  wire  [`AXI_RESP_BITS-1:0]   m1_rresp,
	input  wire                         m1_rlast,
	input  wire                         m1_rvalid,
	input  wire                         m1_rready
);

	logic burst_open;

	// Address handshake to last beat at any master
	always_ff @(posedge ACLK) begin
		if (!ARESETn)
			burst_open <= 1'b0;
		else if ((m0_arvalid && m0_arready) || (m1_arvalid && m1_arready))
			burst_open <= 1'b1;
		else if ((m0_rvalid && m0_rready && m0_rlast) || (m1_rvalid && m1_rready && m1_rlast))
			burst_open <= 1'b0;
	end

	a_one_slave: assert property (@(posedge ACLK) disable iff (!ARESETn)
		$onehot0(s_arvalid))
		else $error("more than one s_arvalid high");

	a_one_master: assert property (@(posedge ACLK) disable iff (!ARESETn)
		!(m0_rvalid && m1_rvalid))
		else $error("m0_rvalid and m1_rvalid high together");

	a_m0_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
		m0_rvalid && !m0_rready |=> m0_rvalid && $stable(m0_rid) && $stable(m0_rdata)
			&& $stable(m0_rresp) && $stable(m0_rlast))
		else $error("m0 read beat changed before its handshake");

	a_m1_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
		m1_rvalid && !m1_rready |=> m1_rvalid && $stable(m1_rid) && $stable(m1_rdata)
			&& $stable(m1_rresp) && $stable(m1_rlast))
		else $error("m1 read beat changed before its handshake");

	a_window: assert property (@(posedge ACLK) disable iff (!ARESETn)
		burst_open |-> !(|s_arvalid))
		else $error("s_arvalid raised while a burst is open");

	// Only OKAY from the slaves or DECERR from the fallback
	a_resp: assert property (@(posedge ACLK) disable iff (!ARESETn)
		(m0_rvalid |-> resp_e'(m0_rresp) inside {RESP_OKAY, RESP_DECERR})
		and (m1_rvalid |-> resp_e'(m1_rresp) inside {RESP_OKAY, RESP_DECERR}))
		else $error("unexpected read response class");

endmodule

`default_nettype wire

// File: bench/axi_read_xbar_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_defines.svh"

module axi_read_xbar_tb import axi_pkg::*; ();

	localparam int NS = `AXI_NUM_SLAVES;
	localparam int MAX_LINES = 32;

	logic                        ACLK = 1'b0;
	logic                        ARESETn = 1'b0;

	logic [`AXI_ID_BITS-1:0]     m0_arid = '0;
	logic [`AXI_ADDR_BITS-1:0]   m0_araddr = '0;
	logic [`AXI_LEN_BITS-1:0]    m0_arlen = '0;
	logic [`AXI_SIZE_BITS-1:0]   m0_arsize = 3'd2;
	logic [`AXI_BURST_BITS-1:0]  m0_arburst = 2'b01;
	logic                        m0_arvalid = 1'b0;
	logic                        m0_arready;
	logic [`AXI_ID_BITS-1:0]     m0_rid;
	logic [`AXI_DATA_BITS-1:0]   m0_rdata;
	logic [`AXI_RESP_BITS-1:0]   m0_rresp;
	logic                        m0_rlast;
	logic                        m0_rvalid;
	logic                        m0_rready = 1'b0;

	logic [`AXI_ID_BITS-1:0]     m1_arid = '0;
	logic [`AXI_ADDR_BITS-1:0]   m1_araddr = '0;
	logic [`AXI_LEN_BITS-1:0]    m1_arlen = '0;
	logic [`AXI_SIZE_BITS-1:0]   m1_arsize = 3'd1;
	logic [`AXI_BURST_BITS-1:0]  m1_arburst = 2'b01;
	logic                        m1_arvalid = 1'b0;
	logic                        m1_arready;
	logic [`AXI_ID_BITS-1:0]     m1_rid;
	logic [`AXI_DATA_BITS-1:0]   m1_rdata;
	logic [`AXI_RESP_BITS-1:0]   m1_rresp;
	logic                        m1_rlast;
	logic                        m1_rvalid;
	logic                        m1_rready = 1'b0;

	logic [`AXI_IDS_BITS-1:0]    s_arid    [0:NS-1];
	logic [`AXI_ADDR_BITS-1:0]   s_araddr  [0:NS-1];
	logic [`AXI_LEN_BITS-1:0]    s_arlen   [0:NS-1];
	logic [`AXI_SIZE_BITS-1:0]   s_arsize  [0:NS-1];
	logic [`AXI_BURST_BITS-1:0]  s_arburst [0:NS-1];
	logic [NS-1:0]               s_arvalid;
	logic [NS-1:0]               s_arready = '0;
	logic [`AXI_IDS_BITS-1:0]    s_rid     [0:NS-1] = '{default: '0};
	logic [`AXI_DATA_BITS-1:0]   s_rdata   [0:NS-1] = '{default: '0};
	logic [`AXI_RESP_BITS-1:0]   s_rresp   [0:NS-1] = '{default: '0};
	logic [NS-1:0]               s_rlast = '0;
	logic [NS-1:0]               s_rvalid = '0;
	logic [NS-1:0]               s_rready;

	// Stimulus word: master, id, address, len, both flag, response class
	logic [51:0]  stim [0:MAX_LINES-1];
	int           num_lines;
	int           limit = 0;
	int           cycle_count;
	int           value_errors = 0;
	int           other_errors = 0;
	int           beats_checked = 0;
	int           issued = 0;
	int           completed = 0;
	logic [31:0]  lcg_state = 32'hadf2c48f;
	logic [1:0]   ar_taken = '0;
	logic         burst_open = 1'b0;
	master_e      last_grant = MASTER_1;
	logic [38:0]  exp0 [$];
	logic [38:0]  exp1 [$];
	master_e      exp_order [$];

	// Slave model state, sampled handshakes come from the rising edge
	logic [NS-1:0]              ar_seen = '0;
	logic [NS-1:0]              r_seen = '0;
	logic [31:0]                seen_addr [0:NS-1] = '{default: '0};
	logic [4:0]                 seen_id   [0:NS-1] = '{default: '0};
	logic [3:0]                 seen_len  [0:NS-1] = '{default: '0};
	logic [NS-1:0]              sl_busy = '0;
	logic [NS-1:0]              sl_wait = '0;
	logic [31:0]                sl_addr [0:NS-1] = '{default: '0};
	logic [4:0]                 sl_id   [0:NS-1] = '{default: '0};
	logic [3:0]                 sl_len  [0:NS-1] = '{default: '0};
	logic [3:0]                 sl_beat [0:NS-1] = '{default: '0};

	axi_read_xbar axi_read_xbar_inst (.*);

	bind axi_read_xbar axi_read_xbar_checker axi_read_xbar_checker_inst (.*);

	initial begin
		forever #4 ACLK = ~ACLK;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_resp(string name, resp_e got, resp_e exp);
		if (got !== exp) begin
			$display("error at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
			value_errors++;
		end
	endtask

	task automatic check_data(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("error at %0t: %s got %h expected %h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_id(string name, logic [3:0] got, logic [3:0] exp);
		if (got !== exp) begin
			$display("error at %0t: %s got %h expected %h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_attr(string name, logic [3:0] got, logic [3:0] exp);
		if (got !== exp) begin
			$display("error at %0t: %s got %h expected %h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_last(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("error at %0t: %s got %b expected %b", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_master(string name, master_e got, master_e exp);
		if (got !== exp) begin
			$display("error at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
			value_errors++;
		end
	endtask

	// One read beat accepted by master m
	task automatic take_beat(master_e m, logic [3:0] id, logic [31:0] data,
			logic [1:0] resp, logic last);
		logic [38:0] exp;
		string       pfx;
		pfx = (m == MASTER_0) ? "m0" : "m1";
		if ((m == MASTER_0 && exp0.size() == 0) || (m == MASTER_1 && exp1.size() == 0)) begin
			$display("%s received a read beat at %0t that it never asked for", pfx, $time);
			other_errors++;
			return;
		end
		if (m == MASTER_0)
			exp = exp0.pop_front();
		else
			exp = exp1.pop_front();
		check_data({pfx, "_rdata"}, data, exp[31:0]);
		check_id({pfx, "_rid"}, id, exp[35:32]);
		check_resp({pfx, "_rresp"}, resp_e'(resp), resp_e'(exp[37:36]));
		check_last({pfx, "_rlast"}, last, exp[38]);
		beats_checked++;
		if (last) begin
			completed++;
			if (exp_order.size() == 0) begin
				$display("%s completed a burst at %0t that was not expected", pfx, $time);
				other_errors++;
			end else begin
				check_master("burst completion order", m, exp_order.pop_front());
			end
		end
	endtask

	task automatic start_request(int idx);
		logic [51:0] w;
		logic [31:0] data;
		logic [38:0] beat;
		w = stim[idx];
		for (int k = 0; k <= int'(w[11:8]); k++) begin
			// Slaves return address plus 4k, the decode slave returns zero
			data = (w[1:0] == RESP_OKAY) ? w[43:12] + 32'(4 * k) : '0;
			beat = {(k == int'(w[11:8])), w[1:0], w[47:44], data};
			if (w[48])
				exp1.push_back(beat);
			else
				exp0.push_back(beat);
		end
		if (w[48]) begin
			m1_arid    = w[47:44];
			m1_araddr  = w[43:12];
			m1_arlen   = w[11:8];
			m1_arvalid = 1'b1;
		end else begin
			m0_arid    = w[47:44];
			m0_araddr  = w[43:12];
			m0_arlen   = w[11:8];
			m0_arvalid = 1'b1;
		end
		issued++;
	endtask

	task automatic wait_bursts();
		while (completed < issued) begin
			@(negedge ACLK);
			if (ar_taken[0])
				m0_arvalid = 1'b0;
			if (ar_taken[1])
				m1_arvalid = 1'b0;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Slave models, one idle cycle then len+1 beats
	//////////////////////////////////////////////////////////////////////

	always @(negedge ACLK) begin
		for (int s = 0; s < NS; s++) begin
			if (!ARESETn) begin
				sl_busy[s] = 1'b0;
				sl_wait[s] = 1'b0;
			end else if (ar_seen[s]) begin
				sl_busy[s] = 1'b1;
				sl_wait[s] = 1'b1;
				sl_addr[s] = seen_addr[s];
				sl_id[s]   = seen_id[s];
				sl_len[s]  = seen_len[s];
				sl_beat[s] = '0;
			end else if (r_seen[s]) begin
				if (s_rlast[s])
					sl_busy[s] = 1'b0;
				else
					sl_beat[s] = sl_beat[s] + 1'b1;
			end
			s_arready[s] = !sl_busy[s];
			if (sl_wait[s]) begin
				s_rvalid[s] = 1'b0;
				sl_wait[s]  = 1'b0;
			end else begin
				s_rvalid[s] = sl_busy[s];
			end
			s_rid[s]   = sl_id[s];
			s_rdata[s] = sl_addr[s] + 32'(sl_beat[s]) * 32'd4;
			s_rresp[s] = RESP_OKAY;
			s_rlast[s] = (sl_beat[s] == sl_len[s]);
		end
	end

	// About one stall cycle in four per master
	always @(negedge ACLK) begin
		m0_rready = (lcg_next() >> 30) != 32'd0;
		m1_rready = (lcg_next() >> 30) != 32'd0;
	end

	always @(posedge ACLK) begin
		for (int s = 0; s < NS; s++) begin
			ar_seen[s]   = ARESETn && s_arvalid[s] && s_arready[s];
			r_seen[s]    = ARESETn && s_rvalid[s] && s_rready[s];
			seen_addr[s] = s_araddr[s];
			seen_id[s]   = s_arid[s];
			seen_len[s]  = s_arlen[s];
			// Size and burst come through from the granted master
			if (ar_seen[s]) begin
				check_attr("s_arsize", s_arsize[s], m1_arready ? m1_arsize : m0_arsize);
				check_attr("s_arburst", s_arburst[s], m1_arready ? m1_arburst : m0_arburst);
			end
		end
		ar_taken = {m1_arvalid && m1_arready, m0_arvalid && m0_arready};
		if (ARESETn) begin
			if (m0_arready || m1_arready) begin
				if (burst_open) begin
					$display("A read address was accepted at %0t while a burst was open", $time);
					other_errors++;
				end
				burst_open = 1'b1;
			end
			if (m0_rvalid && m0_rready) begin
				take_beat(MASTER_0, m0_rid, m0_rdata, m0_rresp, m0_rlast);
				if (m0_rlast)
					burst_open = 1'b0;
			end
			if (m1_rvalid && m1_rready) begin
				take_beat(MASTER_1, m1_rid, m1_rdata, m1_rresp, m1_rlast);
				if (m1_rlast)
					burst_open = 1'b0;
			end
		end
	end

	initial begin
		cycle_count = 0;
		wait (limit > 0);
		while (cycle_count < limit) begin
			@(posedge ACLK);
			cycle_count++;
		end
		$display("Timeout after %0d cycles with %0d of %0d bursts complete",
			cycle_count, completed, issued);
		$display("Verification failed");
		$finish;
	end

	initial begin
		logic [51:0] w;
		master_e     winner;
		int          i;
		int          missing;
		logic        tie_reset_done;
		for (int n = 0; n < MAX_LINES; n++)
			stim[n] = 'x;
		$readmemh("bench/read_stim.txt", stim);
		num_lines = 0;
		while (num_lines < MAX_LINES && !$isunknown(stim[num_lines]))
			num_lines++;
		limit = 4;
		for (int n = 0; n < num_lines; n++)
			limit += 4 * (int'(stim[n][11:8]) + 1) + 10;

		repeat (2) @(negedge ACLK);
		ARESETn = 1'b1;

		tie_reset_done = 1'b0;
		i = 0;
		while (i < num_lines) begin
			w = stim[i];
			if (w[7:4] != 4'd0 && i + 1 < num_lines && !tie_reset_done) begin
				// Reset again so the first tie starts from the reset priority
				ARESETn = 1'b0;
				repeat (2) @(negedge ACLK);
				ARESETn = 1'b1;
				last_grant = MASTER_1;
				tie_reset_done = 1'b1;
			end
			start_request(i);
			if (w[7:4] != 4'd0 && i + 1 < num_lines) begin
				// Tie goes to the master not granted last
				winner = (last_grant == MASTER_0) ? MASTER_1 : MASTER_0;
				exp_order.push_back(winner);
				last_grant = (winner == MASTER_0) ? MASTER_1 : MASTER_0;
				exp_order.push_back(last_grant);
				i++;
				start_request(i);
			end else begin
				exp_order.push_back(master_e'(w[48]));
				last_grant = master_e'(w[48]);
			end
			i++;
			wait_bursts();
		end

		missing = exp0.size() + exp1.size() + exp_order.size();
		if (missing != 0)
			$display("%0d expected beats or completions never arrived", missing);
		$display("Checked %0d beats in %0d bursts: %0d value errors, %0d other errors",
			beats_checked, completed, value_errors, other_errors + (missing != 0));
		if (value_errors == 0 && other_errors == 0 && missing == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/read_stim.txt
// Columns: master _ id _ address _ len _ both _ resp (0 OKAY, 3 DECERR)
// both=1 issues the line together with the next one, which is for the other master
0_3_00000100_3_0_0
1_5_00010040_1_0_0
0_a_00020000_2_0_3
1_7_00000200_0_0_0
0_1_00010000_7_1_0
1_2_00000300_3_0_0
1_c_8000f000_1_0_3
0_4_00010100_f_0_0
0_6_00000040_2_1_0
1_9_00030000_2_0_3
1_e_00010200_4_1_0
0_f_00000400_1_0_0
0_0_0001fff0_3_0_0
1_b_ffff0000_0_0_3
0_d_00050000_5_1_3
1_8_00000800_2_0_0

// File: compile.f
+incdir+include
rtl/axi_pkg.sv
rtl/ar_arbiter.sv
rtl/slave_port.sv
rtl/decode_slave.sv
rtl/r_return_mux.sv
rtl/axi_read_xbar.sv
bench/axi_read_xbar_checker.sv
bench/axi_read_xbar_tb.sv

// File: Bender.yml
package:
  name: axi_read_xbar

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/axi_pkg.sv
      - rtl/ar_arbiter.sv
      - rtl/slave_port.sv
      - rtl/decode_slave.sv
      - rtl/r_return_mux.sv
      - rtl/axi_read_xbar.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/axi_read_xbar_checker.sv
      - bench/axi_read_xbar_tb.sv
